/* project.f */
rtl/gpu_soc_pkg.sv
rtl/shared_ram.sv
rtl/gpu_ctrl_regs.sv
rtl/system_bus.sv
rtl/gpu_soc_top.sv
verif/tb_gpu_soc.sv

/* Bender.yml */
package:
  name: gpu_soc

sources:
  - rtl/gpu_soc_pkg.sv
  - rtl/shared_ram.sv
  - rtl/gpu_ctrl_regs.sv
  - rtl/system_bus.sv
  - rtl/gpu_soc_top.sv
  - target: test
    files:
      - verif/tb_gpu_soc.sv

/* verif/tb_gpu_soc.sv */
// Testbench for the GPU SoC shared RAM, system bus and control registers
`timescale 1ns/1ps
`default_nettype none

module tb_gpu_soc;

	localparam int MEM_BYTES  = 24576;
	localparam int WORDS      = MEM_BYTES / 4;
	localparam int CLK_PERIOD = 20;
	localparam int RST_CYCLES = 8;
	localparam int POOL       = 16;
	localparam int RAND_WR    = 32;
	localparam int GPU_CYCLES = 64;
	localparam int N_REQ      = 132;
	localparam int REQ_LIMIT  = GPU_CYCLES + 8;  // Worst GPU stall per request
	localparam int REQ_CYCLES = 3 * N_REQ + GPU_CYCLES + RST_CYCLES;
	localparam gpu_soc_pkg::reg_off_t CMD_OFF [9] = '{
		gpu_soc_pkg::REG_ADDR, gpu_soc_pkg::REG_ADDR_X, gpu_soc_pkg::REG_ADDR_Y,
		gpu_soc_pkg::REG_IMAGE_WIDTH, gpu_soc_pkg::REG_WIDTH, gpu_soc_pkg::REG_HEIGHT,
		gpu_soc_pkg::REG_X, gpu_soc_pkg::REG_Y, gpu_soc_pkg::REG_CLEAR_COLOR};

	logic                  hdmi_pixClk = 1'b0;
	logic                  arst_n;
	logic                  mem_valid;
	gpu_soc_pkg::cpu_req_t mem_req;
	logic                  mem_ready;
	gpu_soc_pkg::word_t    mem_rdata;
	logic                  gpu_mem_read;
	gpu_soc_pkg::addr_t    gpu_mem_addr;
	logic                  gpu_mem_valid;
	gpu_soc_pkg::half_t    gpu_mem_data;
	gpu_soc_pkg::gpu_cmd_t gpu_cmd;
	logic                  gpu_draw;
	logic                  gpu_clear;
	logic                  swap_buffers;
	logic                  is_vsynced;
	logic                  gpu_busy;
	logic                  hdmi_vsync;

	// Reference model state
	gpu_soc_pkg::word_t    shadow [WORDS];
	int unsigned           pool [POOL];
	gpu_soc_pkg::gpu_cmd_t nxt_cmd = '0;
	gpu_soc_pkg::gpu_cmd_t exp_cmd = '0;
	logic                  nxt_vsync_en = 1'b0;
	logic                  exp_vsync_en = 1'b0;
	logic [2:0]            nxt_pulse = '0;  // draw, clear, swap
	logic [2:0]            exp_pulse = '0;
	logic                  exp_read = 1'b0;
	gpu_soc_pkg::word_t    exp_rdata = '0;
	gpu_soc_pkg::half_t    gpu_exp_q = '0;
	logic [31:0]           lfsr = 32'h32ee9fca;
	int                    reset_edges = 0;
	int                    n_req = 0;
	int                    rd_errs = 0;
	int                    bus_errs = 0;
	int                    gpu_errs = 0;
	int                    reg_errs = 0;
	int                    pulse_errs = 0;
	int                    rst_errs = 0;

	gpu_soc_top #(.MEM_BYTES(MEM_BYTES)) UUT (
		.hdmi_pixClk   (hdmi_pixClk),
		.arst_n        (arst_n),
		.mem_valid     (mem_valid),
		.mem_req       (mem_req),
		.mem_ready     (mem_ready),
		.mem_rdata     (mem_rdata),
		.gpu_mem_read  (gpu_mem_read),
		.gpu_mem_addr  (gpu_mem_addr),
		.gpu_mem_valid (gpu_mem_valid),
		.gpu_mem_data  (gpu_mem_data),
		.gpu_cmd       (gpu_cmd),
		.gpu_draw      (gpu_draw),
		.gpu_clear     (gpu_clear),
		.swap_buffers  (swap_buffers),
		.is_vsynced    (is_vsynced),
		.gpu_busy      (gpu_busy),
		.hdmi_vsync    (hdmi_vsync)
	);

	always #(CLK_PERIOD / 2) hdmi_pixClk = ~hdmi_pixClk;

	always @(posedge hdmi_pixClk) begin
		if (!arst_n)
			reset_edges <= reset_edges + 1;
		if (gpu_mem_read)  // Half-word picked by address bit 1
			gpu_exp_q <= gpu_mem_addr[1] ? shadow[gpu_mem_addr[31:2]][31:16]
			                             : shadow[gpu_mem_addr[31:2]][15:0];
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic show_mismatch(input string sig, input logic [287:0] expv, gotv);
		$display("FAIL %0t ns: %s expected %0h, got %0h", $time, sig, expv, gotv);
	endtask

	// One CPU request held until mem_ready
	task automatic cpu_access(input gpu_soc_pkg::addr_t a, input gpu_soc_pkg::word_t d,
			input gpu_soc_pkg::strb_t s, input gpu_soc_pkg::word_t exp);
		int waited;
		@(posedge hdmi_pixClk);
		mem_valid    <= 1'b1;
		mem_req      <= '{addr: a, wdata: d, wstrb: s};
		exp_read     <= (s == '0);
		exp_rdata    <= exp;
		exp_cmd      <= nxt_cmd;
		exp_vsync_en <= nxt_vsync_en;
		exp_pulse    <= nxt_pulse;
		waited = 0;
		do begin
			@(posedge hdmi_pixClk);
			waited++;
		end while (!mem_ready && waited < REQ_LIMIT);
		if (!mem_ready) begin
			bus_errs++;
			$display("Request to address %h got no mem_ready in %0d cycles", a, REQ_LIMIT);
		end
		mem_valid <= 1'b0;
		exp_read  <= 1'b0;
		exp_pulse <= '0;
		n_req++;
	endtask

	task automatic ram_access(input int unsigned idx, input gpu_soc_pkg::word_t d,
			input gpu_soc_pkg::strb_t s);
		cpu_access(gpu_soc_pkg::addr_t'(idx * 4), d, s, shadow[idx]);
		for (int b = 0; b < 4; b++) begin
			if (s[b])
				shadow[idx][8*b +: 8] = d[8*b +: 8];
		end
	endtask

	task automatic reg_write(input gpu_soc_pkg::reg_off_t off, input gpu_soc_pkg::word_t d,
			input gpu_soc_pkg::strb_t s);
		if (s == 4'hF) begin
			for (int i = 0; i < 9; i++) begin
				if (CMD_OFF[i] == off)
					nxt_cmd[(8-i)*32 +: 32] = d;  // addr is the top field
			end
			nxt_pulse[2] = (off == gpu_soc_pkg::REG_DRAW) && d[0];
			nxt_pulse[1] = (off == gpu_soc_pkg::REG_CLEAR) && d[0];
			nxt_pulse[0] = (off == gpu_soc_pkg::REG_SWAP) && d[0];
			if (off == gpu_soc_pkg::REG_VSYNC_EN)
				nxt_vsync_en = d[0];
		end
		cpu_access(gpu_soc_pkg::addr_t'(MEM_BYTES + off), d, s, '0);
		nxt_pulse = '0;
	endtask

	task automatic reg_read(input gpu_soc_pkg::reg_off_t off, input gpu_soc_pkg::word_t exp);
		cpu_access(gpu_soc_pkg::addr_t'(MEM_BYTES + off), '0, 4'h0, exp);
	endtask

	// GPU reads on about half of the cycles
	task automatic gpu_traffic();
		logic [31:0] k;
		for (int c = 0; c < GPU_CYCLES; c++) begin
			@(posedge hdmi_pixClk);
			k = take_bits(4);
			gpu_mem_read <= (take_bits(1) != 0);
			gpu_mem_addr <= (pool[k] << 2) | (take_bits(1) << 1);
		end
		@(posedge hdmi_pixClk);
		gpu_mem_read <= 1'b0;
	endtask

	a_rdata: assert property (@(posedge hdmi_pixClk) disable iff (!arst_n)
		mem_ready && exp_read |-> mem_rdata == exp_rdata)
		else begin
			rd_errs++;
			show_mismatch("mem_rdata", $sampled(exp_rdata), $sampled(mem_rdata));
		end
	a_latency: assert property (@(posedge hdmi_pixClk) disable iff (!arst_n)
		mem_valid && !mem_ready && !gpu_mem_read |=> mem_ready)
		else begin
			bus_errs++;
			show_mismatch("mem_ready", 1, $sampled(mem_ready));
		end
	a_stall: assert property (@(posedge hdmi_pixClk) disable iff (!arst_n)
		gpu_mem_read |=> !mem_ready)
		else begin
			bus_errs++;
			show_mismatch("mem_ready", 0, $sampled(mem_ready));
		end
	a_gpu_valid: assert property (@(posedge hdmi_pixClk) disable iff (!arst_n)
		gpu_mem_read |=> gpu_mem_valid)
		else begin
			gpu_errs++;
			show_mismatch("gpu_mem_valid", 1, $sampled(gpu_mem_valid));
		end
	a_gpu_data: assert property (@(posedge hdmi_pixClk) disable iff (!arst_n)
		gpu_mem_read |=> gpu_mem_data == gpu_exp_q)
		else begin
			gpu_errs++;
			show_mismatch("gpu_mem_data", $sampled(gpu_exp_q), $sampled(gpu_mem_data));
		end
	a_cmd: assert property (@(posedge hdmi_pixClk) disable iff (!arst_n)
		!mem_valid || mem_ready |-> gpu_cmd == exp_cmd)
		else begin
			reg_errs++;
			show_mismatch("gpu_cmd", $sampled(exp_cmd), $sampled(gpu_cmd));
		end
	a_vsync_en: assert property (@(posedge hdmi_pixClk) disable iff (!arst_n)
		!mem_valid || mem_ready |-> is_vsynced == exp_vsync_en)
		else begin
			reg_errs++;
			show_mismatch("is_vsynced", $sampled(exp_vsync_en), $sampled(is_vsynced));
		end
	a_pulse: assert property (@(posedge hdmi_pixClk) disable iff (!arst_n)
		{gpu_draw, gpu_clear, swap_buffers} == (mem_ready ? exp_pulse : 3'b000))
		else begin
			pulse_errs++;
			show_mismatch("{gpu_draw,gpu_clear,swap_buffers}",
				$sampled(mem_ready) ? $sampled(exp_pulse) : 3'b000,
				$sampled({gpu_draw, gpu_clear, swap_buffers}));
		end
	a_reset_ctl: assert property (@(posedge hdmi_pixClk)
		(!arst_n && reset_edges > 0) || $rose(arst_n) |->
		{mem_ready, gpu_mem_valid, gpu_draw, gpu_clear, swap_buffers, is_vsynced} == 6'b0)
		else begin
			rst_errs++;
			show_mismatch(
				"{mem_ready,gpu_mem_valid,gpu_draw,gpu_clear,swap_buffers,is_vsynced}", 0,
				$sampled({mem_ready, gpu_mem_valid, gpu_draw, gpu_clear,
				swap_buffers, is_vsynced}));
		end
	a_reset_cmd: assert property (@(posedge hdmi_pixClk)
		(!arst_n && reset_edges > 0) || $rose(arst_n) |-> gpu_cmd == '0)
		else begin
			rst_errs++;
			show_mismatch("gpu_cmd", 0, $sampled(gpu_cmd));
		end

	initial begin
		#(4 * REQ_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d ns, the run did not finish", $time);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		int unsigned        idx;
		gpu_soc_pkg::word_t data;
		gpu_soc_pkg::strb_t strb;
		logic               bit_v;
		int                 total;
		arst_n       = 1'b0;
		mem_valid    = 1'b0;
		mem_req      = '0;
		gpu_mem_read = 1'b0;
		gpu_mem_addr = '0;
		gpu_busy     = 1'b0;
		hdmi_vsync   = 1'b0;
		for (int i = 0; i < POOL; i++)
			pool[i] = take_bits(13) % WORDS;
		repeat (RST_CYCLES) @(posedge hdmi_pixClk);
		arst_n <= 1'b1;

		for (int i = 0; i < POOL; i++)
			ram_access(pool[i], take_bits(32), 4'hF);
		for (int i = 0; i < RAND_WR; i++) begin
			idx  = pool[take_bits(4)];
			data = take_bits(32);
			strb = gpu_soc_pkg::strb_t'(take_bits(4));  // Zero strobe gives a read
			ram_access(idx, data, strb);
		end
		for (int i = 0; i < POOL; i++)
			ram_access(pool[i], '0, 4'h0);

		fork
			gpu_traffic();
			for (int i = 0; i < POOL; i++)
				ram_access(pool[i], '0, 4'h0);
		join

		for (int i = 0; i < 9; i++)
			reg_write(CMD_OFF[i], take_bits(32), 4'hF);
		for (int i = 0; i < 9; i++) begin
			data = take_bits(32);
			strb = gpu_soc_pkg::strb_t'(take_bits(4));
			if (strb == 4'hF || strb == 4'h0)
				strb = 4'h6;
			reg_write(CMD_OFF[i], data, strb);
		end
		for (int i = 0; i < 9; i++)
			reg_read(CMD_OFF[i], '0);

		reg_write(gpu_soc_pkg::REG_DRAW, 32'h1, 4'hF);
		reg_write(gpu_soc_pkg::REG_DRAW, 32'hFFFF_FFFE, 4'hF);
		reg_write(gpu_soc_pkg::REG_DRAW, 32'h1, 4'h1);  // Partial strobe gives no pulse
		reg_write(gpu_soc_pkg::REG_CLEAR, 32'h1, 4'hF);
		reg_write(gpu_soc_pkg::REG_CLEAR, 32'h0, 4'hF);
		reg_write(gpu_soc_pkg::REG_SWAP, 32'h1, 4'hF);
		reg_write(gpu_soc_pkg::REG_SWAP, 32'h0, 4'hF);
		reg_write(gpu_soc_pkg::REG_VSYNC_EN, 32'h1, 4'hF);
		reg_write(gpu_soc_pkg::REG_VSYNC_EN, 32'h0, 4'hF);
		reg_write(gpu_soc_pkg::REG_VSYNC_EN, 32'h1, 4'hF);

		for (int i = 0; i < 4; i++) begin
			bit_v = (take_bits(1) != 0);
			gpu_busy <= bit_v;
			reg_read(gpu_soc_pkg::REG_BUSY, {31'b0, bit_v});
			bit_v = (take_bits(1) != 0);
			hdmi_vsync <= bit_v;
			reg_read(gpu_soc_pkg::REG_VSYNC, {31'b0, bit_v});
		end
		reg_read(gpu_soc_pkg::REG_DRAW, '0);
		reg_read(gpu_soc_pkg::REG_CLEAR, '0);
		reg_read(gpu_soc_pkg::REG_SWAP, '0);
		reg_read(gpu_soc_pkg::REG_VSYNC_EN, '0);
		reg_read(9'h104, '0);  // Hole inside the window
		cpu_access(gpu_soc_pkg::addr_t'(MEM_BYTES + gpu_soc_pkg::REG_WINDOW), '0, 4'h0, '0);
		cpu_access(32'hFFFF_FFFC, '0, 4'h0, '0);

		repeat (2) @(posedge hdmi_pixClk);
		total = rd_errs + bus_errs + gpu_errs + reg_errs + pulse_errs + rst_errs;
		$display("%0d requests, errors rdata %0d bus %0d gpu %0d regs %0d pulses %0d reset %0d",
			n_req, rd_errs, bus_errs, gpu_errs, reg_errs, pulse_errs, rst_errs);
		if (total == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/gpu_soc_top.sv */
// GPU SoC top joining the system bus, shared RAM and control registers
`timescale 1ns/1ps
`default_nettype none

module gpu_soc_top #(
	parameter int MEM_BYTES = 24576
) (
	input  wire                    hdmi_pixClk,
	input  wire                    arst_n,
	input  wire                    mem_valid,
	input  gpu_soc_pkg::cpu_req_t  mem_req,
	output logic                   mem_ready,
	output gpu_soc_pkg::word_t     mem_rdata,
	input  wire                    gpu_mem_read,
	input  gpu_soc_pkg::addr_t     gpu_mem_addr,
	output logic                   gpu_mem_valid,
	output gpu_soc_pkg::half_t     gpu_mem_data,
	output gpu_soc_pkg::gpu_cmd_t  gpu_cmd,
	output logic                   gpu_draw,
	output logic                   gpu_clear,
	output logic                   swap_buffers,
	output logic                   is_vsynced,
	input  wire                    gpu_busy,
	input  wire                    hdmi_vsync
);

	logic                  cpu_en;
	logic                  reg_en;
	gpu_soc_pkg::reg_off_t reg_off;
	gpu_soc_pkg::cpu_req_t bus_req;
	gpu_soc_pkg::word_t    ram_rdata;
	gpu_soc_pkg::word_t    reg_rdata;

	system_bus #(.MEM_BYTES(MEM_BYTES)) u_bus (
		.hdmi_pixClk  (hdmi_pixClk),
		.arst_n       (arst_n),
		.mem_valid    (mem_valid),
		.gpu_mem_read (gpu_mem_read),
		.mem_req      (mem_req),
		.ram_rdata    (ram_rdata),
		.reg_rdata    (reg_rdata),
		.mem_ready    (mem_ready),
		.mem_rdata    (mem_rdata),
		.cpu_en       (cpu_en),
		.reg_en       (reg_en),
		.reg_off      (reg_off),
		.bus_req      (bus_req)
	);

	shared_ram #(.MEM_BYTES(MEM_BYTES)) u_ram (
		.hdmi_pixClk   (hdmi_pixClk),
		.arst_n        (arst_n),
		.cpu_en        (cpu_en),
		.gpu_mem_read  (gpu_mem_read),
		.bus_req       (bus_req),
		.gpu_mem_addr  (gpu_mem_addr),
		.ram_rdata     (ram_rdata),
		.gpu_mem_valid (gpu_mem_valid),
		.gpu_mem_data  (gpu_mem_data)
	);

	gpu_ctrl_regs u_regs (
		.hdmi_pixClk  (hdmi_pixClk),
		.arst_n       (arst_n),
		.reg_en       (reg_en),
		.reg_off      (reg_off),
		.bus_req      (bus_req),
		.gpu_busy     (gpu_busy),
		.hdmi_vsync   (hdmi_vsync),
		.reg_rdata    (reg_rdata),
		.gpu_cmd      (gpu_cmd),
		.gpu_draw     (gpu_draw),
		.gpu_clear    (gpu_clear),
		.swap_buffers (swap_buffers),
		.is_vsynced   (is_vsynced)
	);

endmodule

`default_nettype wire

/* rtl/system_bus.sv */
// System bus with CPU request acceptance, GPU priority and address decode
`timescale 1ns/1ps
`default_nettype none

module system_bus #(
	parameter int MEM_BYTES = 24576
) (
	input  wire                    hdmi_pixClk,
	input  wire                    arst_n,
	input  wire                    mem_valid,
	input  wire                    gpu_mem_read,
	input  gpu_soc_pkg::cpu_req_t  mem_req,
	input  gpu_soc_pkg::word_t     ram_rdata,
	input  gpu_soc_pkg::word_t     reg_rdata,
	output logic                   mem_ready,
	output gpu_soc_pkg::word_t     mem_rdata,
	output logic                   cpu_en,
	output logic                   reg_en,
	output gpu_soc_pkg::reg_off_t  reg_off,
	output gpu_soc_pkg::cpu_req_t  bus_req
);

	localparam gpu_soc_pkg::addr_t RAM_END = gpu_soc_pkg::addr_t'(MEM_BYTES);
	localparam gpu_soc_pkg::addr_t REG_END =
		gpu_soc_pkg::addr_t'(MEM_BYTES + gpu_soc_pkg::REG_WINDOW);

	logic               accept;
	logic               in_ram;
	logic               in_reg;
	logic               sel_ram;
	logic               sel_reg;
	gpu_soc_pkg::addr_t win_off;

	// GPU reads win, the CPU just waits
	assign accept = mem_valid && !mem_ready && !gpu_mem_read;

	assign in_ram  = mem_req.addr < RAM_END;
	assign in_reg  = (mem_req.addr >= RAM_END) && (mem_req.addr < REG_END);
	assign win_off = mem_req.addr - RAM_END;

	assign cpu_en  = accept && in_ram;
	assign reg_en  = accept && in_reg;
	assign reg_off = gpu_soc_pkg::reg_off_t'(win_off);
	assign bus_req = mem_req;

	always_ff @(posedge hdmi_pixClk or negedge arst_n) begin
		if (!arst_n) begin
			mem_ready <= 1'b0;
			sel_ram   <= 1'b0;
			sel_reg   <= 1'b0;
		end else begin
			mem_ready <= accept;
			if (accept) begin
				sel_ram <= in_ram;
				sel_reg <= in_reg;
			end
		end
	end

	// Unmapped reads see zero
	always_comb begin
		if (sel_ram)
			mem_rdata = ram_rdata;
		else if (sel_reg)
			mem_rdata = reg_rdata;
		else
			mem_rdata = '0;
	end

	a_ready_pulse: assert property (@(posedge hdmi_pixClk) disable iff (!arst_n)
		mem_ready |=> !mem_ready);

endmodule

`default_nettype wire

/* rtl/gpu_ctrl_regs.sv */
// GPU control registers, command strobes and status read-back
`timescale 1ns/1ps
`default_nettype none

module gpu_ctrl_regs (
	input  wire                    hdmi_pixClk,
	input  wire                    arst_n,
	input  wire                    reg_en,
	input  gpu_soc_pkg::reg_off_t  reg_off,
	input  gpu_soc_pkg::cpu_req_t  bus_req,
	input  wire                    gpu_busy,
	input  wire                    hdmi_vsync,
	output gpu_soc_pkg::word_t     reg_rdata,
	output gpu_soc_pkg::gpu_cmd_t  gpu_cmd,
	output logic                   gpu_draw,
	output logic                   gpu_clear,
	output logic                   swap_buffers,
	output logic                   is_vsynced
);

	logic wr;
	logic rd;

	// Only full-word writes reach the registers
	assign wr = reg_en && (&bus_req.wstrb);
	assign rd = reg_en && (bus_req.wstrb == '0);

	always_ff @(posedge hdmi_pixClk or negedge arst_n) begin
		if (!arst_n) begin
			gpu_cmd      <= '0;
			gpu_draw     <= 1'b0;
			gpu_clear    <= 1'b0;
			swap_buffers <= 1'b0;
			is_vsynced   <= 1'b0;
		end else begin
			gpu_draw     <= 1'b0;
			gpu_clear    <= 1'b0;
			swap_buffers <= 1'b0;
			if (wr) begin
				case (reg_off)
					gpu_soc_pkg::REG_ADDR:        gpu_cmd.addr        <= bus_req.wdata;
					gpu_soc_pkg::REG_ADDR_X:      gpu_cmd.addr_x      <= bus_req.wdata;
					gpu_soc_pkg::REG_ADDR_Y:      gpu_cmd.addr_y      <= bus_req.wdata;
					gpu_soc_pkg::REG_IMAGE_WIDTH: gpu_cmd.image_width <= bus_req.wdata;
					gpu_soc_pkg::REG_WIDTH:       gpu_cmd.width       <= bus_req.wdata;
					gpu_soc_pkg::REG_HEIGHT:      gpu_cmd.height      <= bus_req.wdata;
					gpu_soc_pkg::REG_X:           gpu_cmd.x           <= bus_req.wdata;
					gpu_soc_pkg::REG_Y:           gpu_cmd.y           <= bus_req.wdata;
					gpu_soc_pkg::REG_CLEAR_COLOR: gpu_cmd.clear_color <= bus_req.wdata;
					gpu_soc_pkg::REG_DRAW:        gpu_draw            <= bus_req.wdata[0];
					gpu_soc_pkg::REG_CLEAR:       gpu_clear           <= bus_req.wdata[0];
					gpu_soc_pkg::REG_SWAP:        swap_buffers        <= bus_req.wdata[0];
					gpu_soc_pkg::REG_VSYNC_EN:    is_vsynced          <= bus_req.wdata[0];
					default: ;  // Read-only or unmapped offset
				endcase
			end
		end
	end

	// Status is sampled at the accepting edge
	always_ff @(posedge hdmi_pixClk) begin
		if (rd) begin
			case (reg_off)
				gpu_soc_pkg::REG_BUSY:  reg_rdata <= {31'b0, gpu_busy};
				gpu_soc_pkg::REG_VSYNC: reg_rdata <= {31'b0, hdmi_vsync};
				default:                reg_rdata <= '0;
			endcase
		end
	end

	// Each command write is acknowledged before the next can arrive
	a_draw_pulse: assert property (@(posedge hdmi_pixClk) disable iff (!arst_n)
		gpu_draw |=> !gpu_draw);
	a_clear_pulse: assert property (@(posedge hdmi_pixClk) disable iff (!arst_n)
		gpu_clear |=> !gpu_clear);

endmodule

`default_nettype wire

/* rtl/shared_ram.sv */
// Shared word RAM with byte-strobed CPU port and GPU half-word read port
`timescale 1ns/1ps
`default_nettype none

module shared_ram #(
	parameter int MEM_BYTES = 24576
) (
	input  wire                    hdmi_pixClk,
	input  wire                    arst_n,
	input  wire                    cpu_en,
	input  wire                    gpu_mem_read,
	input  gpu_soc_pkg::cpu_req_t  bus_req,
	input  gpu_soc_pkg::addr_t     gpu_mem_addr,
	output gpu_soc_pkg::word_t     ram_rdata,
	output logic                   gpu_mem_valid,
	output gpu_soc_pkg::half_t     gpu_mem_data
);

	localparam int WORDS = MEM_BYTES / 4;
	localparam int AW    = (WORDS > 1) ? $clog2(WORDS) : 1;

	gpu_soc_pkg::word_t mem [0:WORDS-1];

	logic [AW-1:0]      cpu_idx;
	logic [AW-1:0]      gpu_idx;
	gpu_soc_pkg::word_t gpu_word;
	logic               half_sel;

	assign cpu_idx = bus_req.addr[AW+1:2];
	assign gpu_idx = gpu_mem_addr[AW+1:2];

	// CPU port writes only the strobed bytes
	always_ff @(posedge hdmi_pixClk) begin
		if (cpu_en) begin
			for (int b = 0; b < 4; b++) begin
				if (bus_req.wstrb[b])
					mem[cpu_idx][8*b +: 8] <= bus_req.wdata[8*b +: 8];
			end
			if (bus_req.wstrb == '0)
				ram_rdata <= mem[cpu_idx];
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (gpu_mem_read) begin
			gpu_word <= mem[gpu_idx];
			half_sel <= gpu_mem_addr[1];  // Upper half when set
		end
	end

	always_ff @(posedge hdmi_pixClk or negedge arst_n) begin
		if (!arst_n)
			gpu_mem_valid <= 1'b0;
		else
			gpu_mem_valid <= gpu_mem_read;
	end

	assign gpu_mem_data = half_sel ? gpu_word[31:16] : gpu_word[15:0];

	// Bus must hold the CPU off while the GPU reads
	a_no_port_clash: assert property (@(posedge hdmi_pixClk) disable iff (!arst_n)
		!(cpu_en && gpu_mem_read));

endmodule

`default_nettype wire

/* rtl/gpu_soc_pkg.sv */
// GPU SoC package with bus types, request and command structs, register map
`default_nettype none

package gpu_soc_pkg;

	typedef logic [31:0] word_t;     // CPU and RAM data word
	typedef logic [31:0] addr_t;     // CPU byte address
	typedef logic [3:0]  strb_t;     // All zero means read
	typedef logic [15:0] half_t;     // GPU read data
	typedef logic [8:0]  reg_off_t;  // Byte offset in register window

	// Register window size in bytes, placed right above the RAM
	localparam int REG_WINDOW = 512;

	typedef struct packed {
		addr_t addr;
		word_t wdata;
		strb_t wstrb;
	} cpu_req_t;

	// Draw command fields as seen by the GPU
	typedef struct packed {
		word_t addr;
		word_t addr_x;
		word_t addr_y;
		word_t image_width;
		word_t width;
		word_t height;
		word_t x;
		word_t y;
		word_t clear_color;
	} gpu_cmd_t;

	localparam reg_off_t REG_ADDR        = 9'h000;
	localparam reg_off_t REG_ADDR_X      = 9'h004;
	localparam reg_off_t REG_ADDR_Y      = 9'h008;
	localparam reg_off_t REG_IMAGE_WIDTH = 9'h00C;
	localparam reg_off_t REG_WIDTH       = 9'h010;
	localparam reg_off_t REG_HEIGHT      = 9'h014;
	localparam reg_off_t REG_X           = 9'h018;
	localparam reg_off_t REG_Y           = 9'h01C;
	localparam reg_off_t REG_DRAW        = 9'h020;  // Pulse
	localparam reg_off_t REG_CLEAR_COLOR = 9'h024;
	localparam reg_off_t REG_CLEAR       = 9'h028;  // Pulse
	localparam reg_off_t REG_BUSY        = 9'h02C;  // Read only

	// Display control
	localparam reg_off_t REG_SWAP        = 9'h100;  // Pulse
	localparam reg_off_t REG_VSYNC       = 9'h108;  // Read only
	localparam reg_off_t REG_VSYNC_EN    = 9'h10C;

endpackage

`default_nettype wire
